/* list.f */
verilog/csr_pkg.sv
verilog/csr_regs.sv
verilog/ctr_ctl_fsm.sv
verilog/cycle_counters.sv
verilog/par_rd_mux.sv
verilog/ctrl_status_top.sv
sim/ctrl_status_assert.sv
sim/tb_ctrl_status.sv

/* sim/ctrl_status_assert.sv */
////////////////////
// concurrent checks on the register block and the counter FSM
// bound into csr_regs and ctr_ctl_fsm, ports a block lacks are tied off
////////////////////

`timescale 1ns/100ps

module ctrl_status_assert import csr_pkg::*;
(
    input logic              cpu_clk,
    input logic              rx_ovfl_rst,
    input cpu_bus_t          bus,
    input logic [ctrl_w-1:0] ctrl,
    input logic              rx_overflow,
    input ctr_state_t        ctr_state,
    input logic              ctr_clr
);

    // control word moves only on a set_ctrl write
    ctrl_write_only: assert property (@(posedge cpu_clk) disable iff (rx_ovfl_rst)
        !$stable(ctrl) |-> $past(bus.wr_reg && bus.op[set_ctrl]) || $past(rx_ovfl_rst))
        else $error("ctrl changed without a set_ctrl write");

    // sticky flag only drops on its clear event
    ovfl_sticky: assert property (@(posedge cpu_clk) disable iff (rx_ovfl_rst)
        $fell(rx_overflow) |-> $past(bus.wr_evt && bus.op[clr_rx_ovfl]) || $past(rx_ovfl_rst))
        else $error("overflow flag fell without a clear event");

    // 2'b11 is never used
    state_legal: assert property (@(posedge cpu_clk) disable iff (rx_ovfl_rst)
        ctr_state != 2'b11)
        else $error("counter FSM in unused encoding");

    // counter clear is a single cycle pulse
    clr_one_cycle: assert property (@(posedge cpu_clk) disable iff (rx_ovfl_rst)
        ctr_clr |=> !ctr_clr)
        else $error("ctr_clr held longer than one cycle");

endmodule

bind csr_regs ctrl_status_assert u_regs_assert (
    .cpu_clk     (cpu_clk),
    .rx_ovfl_rst (rx_ovfl_rst),
    .bus         (bus),
    .ctrl        (ctrl),
    .rx_overflow (rx_overflow),
    .ctr_state   (ctr_state),
    .ctr_clr     (1'b0)
);

bind ctr_ctl_fsm ctrl_status_assert u_fsm_assert (
    .cpu_clk     (cpu_clk),
    .rx_ovfl_rst (rx_ovfl_rst),
    .bus         (bus),
    .ctrl        ('0),
    .rx_overflow (1'b0),
    .ctr_state   (ctr_state),
    .ctr_clr     (ctr_clr)
);

/* sim/tb_ctrl_status.sv */
////////////////////
// testbench for the CPU control and status block
// drives the register bus from an LFSR and checks all outputs
// against a cycle model after every clock edge
////////////////////

`timescale 1ns/100ps

module tb_ctrl_status import csr_pkg::*;
();

    localparam int clk_period = 20;
    localparam int drive_dly  = 2;
    localparam int rst_cycles = 16;
    localparam int n_ctrl_wr  = 12;
    localparam int n_ovfl     = 4;
    localparam int n_srq      = 8;
    localparam int n_ctr_evt  = 40;
    localparam int n_host     = 16;
    // one long run and pause carries both counters into byte 2
    localparam int n_long_run   = 32'h1_0123;
    localparam int n_long_pause = 32'h234;
    // worst case cycles of each test section
    localparam int test_cycles = rst_cycles + 6 + n_ctrl_wr * 5 + n_ovfl * 21
                               + n_srq * 11 + n_ctr_evt * 11 + 10 + n_host
                               + n_long_run + n_long_pause + 14;
    localparam int watchdog_ns = test_cycles * clk_period + 1000;
    localparam logic [31:0] lfsr_seed = 32'h4dbd;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    // expected state of the block
    typedef struct packed {
        logic [ctrl_w-1:0] ctrl;
        logic              ovfl_meta;
        logic              ovfl_sync;
        logic              ovfl_prev;
        logic              ovfl_flag;
        logic              noted;
        logic              srq;
        ctr_state_t        state;
        logic [ctr_w-1:0]  free;
        logic [ctr_w-1:0]  gated;
    } model_t;

    logic              cpu_clk;
    logic              rx_ovfl_rst;
    cpu_bus_t          bus;
    logic              adc_ovfl;
    logic              host_srq;
    logic              if_mag;
    logic [par_w-1:0]  host_dout;
    logic [ctrl_w-1:0] ctrl;
    logic              adc_clken;
    logic              eeprom_wp;
    logic              host_intr;
    logic              srq_bit;
    logic [par_w-1:0]  par;
    model_t            ref_m;
    logic [31:0]       lfsr_state;
    int                errors;

    ctrl_status_top dut (
        .cpu_clk     (cpu_clk),
        .rx_ovfl_rst (rx_ovfl_rst),
        .bus         (bus),
        .adc_ovfl    (adc_ovfl),
        .host_srq    (host_srq),
        .if_mag      (if_mag),
        .host_dout   (host_dout),
        .ctrl        (ctrl),
        .adc_clken   (adc_clken),
        .eeprom_wp   (eeprom_wp),
        .host_intr   (host_intr),
        .srq_bit     (srq_bit),
        .par         (par)
    );

    always #(clk_period / 2) cpu_clk = ~cpu_clk;

    ////////////////////
    // reference model

    // next state after one edge with the inputs seen at that edge
    function automatic model_t model_step(model_t m, cpu_bus_t b, logic rst, logic ovfl_in,
                                          logic srq_in);
        model_t n;
        logic   ovfl_rise;
        logic   srq_rd;
        logic   clr;
        n         = m;
        ovfl_rise = m.ovfl_sync & ~m.ovfl_prev;
        srq_rd    = b.rd_reg & b.op[get_srq];
        clr       = b.wr_evt & b.op[cpu_ctr_clr];
        if (b.wr_reg && b.op[set_ctrl])
            n.ctrl = b.tos[ctrl_w-1:0];
        // two sync stages, then the edge feeds the sticky flag
        n.ovfl_meta = ovfl_in;
        n.ovfl_sync = m.ovfl_meta;
        n.ovfl_prev = m.ovfl_sync;
        if (b.wr_evt && b.op[clr_rx_ovfl])
            n.ovfl_flag = ovfl_rise;
        else
            n.ovfl_flag = m.ovfl_flag | ovfl_rise;
        n.noted = srq_rd ? srq_in : (m.noted | srq_in);
        if (srq_rd)
            n.srq = m.noted;
        // clear beats enable beats disable
        if (clr)
            n.state = ctr_idle;
        else if (b.wr_evt && b.op[cpu_ctr_ena])
            n.state = ctr_run;
        else if (b.wr_evt && b.op[cpu_ctr_dis] && m.state == ctr_run)
            n.state = ctr_pause;
        n.free  = clr ? '0 : m.free + 1;
        n.gated = clr ? '0 : m.gated + (m.state == ctr_run);
        if (rst)
            n = '0;
        return n;
    endfunction

    // expected parallel input in the current cycle
    function automatic logic [par_w-1:0] model_par(model_t m, cpu_bus_t b, logic mag,
                                                   logic [par_w-1:0] host);
        logic [par_w-1:0] p;
        p = host;
        if (b.rd_reg && b.op[get_status])
            p = {m.ovfl_flag, m.state, mag, fpga_ver, clock_id, fpga_id};
        // byte 0 has top priority, so it is applied last
        for (int k = 3; k >= 0; k--)
            if (b.rd_reg && b.op[get_cpu_ctr0 + k])
                p = {m.gated[8*k +: 8], m.free[8*k +: 8]};
        return p;
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    ////////////////////
    // stimulus helpers

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic cpu_bus_t bus_cmd(int op_bit, logic [31:0] tos, logic rd, logic wr,
                                         logic evt);
        cpu_bus_t b;
        b            = '0;
        b.op[op_bit] = 1'b1;
        b.tos        = tos;
        b.rd_reg     = rd;
        b.wr_reg     = wr;
        b.wr_evt     = evt;
        return b;
    endfunction

    // new bus word and host data just after the edge
    task step_cycle(input cpu_bus_t b);
        @(posedge cpu_clk);
        #(drive_dly);
        bus       = b;
        host_dout = par_w'(rand_bits(par_w));
    endtask

    task strobe_once(input cpu_bus_t b);
        step_cycle(b);
        step_cycle('0);
    endtask

    task wait_cycles(input int n);
        repeat (n) step_cycle('0);
    endtask

    task read_reg(input int op_bit, output logic [par_w-1:0] value);
        step_cycle(bus_cmd(op_bit, '0, 1'b1, 1'b0, 1'b0));
        @(negedge cpu_clk);
        value = par;
        step_cycle('0);
    endtask

    ////////////////////
    // compare every cycle, mid cycle where all outputs are settled

    initial
    begin
        ref_m = '0;
        forever
        begin
            @(posedge cpu_clk);
            ref_m = model_step(ref_m, bus, rx_ovfl_rst, adc_ovfl, host_srq);
            @(negedge cpu_clk);
            check_equal(par, model_par(ref_m, bus, if_mag, host_dout), "par");
            check_equal(ctrl, ref_m.ctrl, "ctrl");
            check_equal(adc_clken, ref_m.ctrl[ctrl_osc_en], "adc_clken");
            check_equal(eeprom_wp, ref_m.ctrl[ctrl_eeprom_wp], "eeprom_wp");
            check_equal(host_intr, ref_m.ctrl[ctrl_interrupt], "host_intr");
            check_equal(srq_bit, ref_m.srq, "srq_bit");
        end
    end

    initial
    begin
        #(watchdog_ns);
        $display("timeout: the test sequence did not finish within %0d ns", watchdog_ns);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    ////////////////////
    // test sequence

    initial
    begin : stimulus
        logic [31:0]      tos;
        logic [par_w-1:0] val;
        logic             had;
        int               pick;
        cpu_clk     = 1'b0;
        lfsr_state  = lfsr_seed;
        errors      = 0;
        rx_ovfl_rst = 1'b1;
        bus         = '0;
        adc_ovfl    = 1'b0;
        host_srq    = 1'b0;
        if_mag      = 1'b0;
        host_dout   = '0;
        repeat (rst_cycles) @(posedge cpu_clk);
        #(drive_dly);
        rx_ovfl_rst = 1'b0;

        // reset values and identity codes
        read_reg(get_status, val);
        check_equal(val, {1'b0, ctr_idle, 1'b0, fpga_ver, clock_id, fpga_id}, "status at reset");
        check_equal(ctrl, '0, "ctrl at reset");
        check_equal({host_intr, eeprom_wp, adc_clken}, '0, "pins at reset");
        check_equal(srq_bit, 1'b0, "srq_bit at reset");

        // control register writes with random gaps
        for (int i = 0; i < n_ctrl_wr; i++)
        begin
            tos = rand_bits(32);
            strobe_once(bus_cmd(set_ctrl, tos, 1'b0, 1'b1, 1'b0));
            check_equal(ctrl, tos[ctrl_w-1:0], "ctrl after write");
            check_equal({host_intr, eeprom_wp, adc_clken},
                        {tos[ctrl_interrupt], tos[ctrl_eeprom_wp], tos[ctrl_osc_en]}, "pins");
            wait_cycles(rand_bits(2));
        end

        // overflow pulses of three cycles or more
        for (int i = 0; i < n_ovfl; i++)
        begin
            adc_ovfl = 1'b1;
            wait_cycles(3 + rand_bits(3));
            adc_ovfl = 1'b0;
            wait_cycles(3);
            read_reg(get_status, val);
            check_equal(val[15], 1'b1, "overflow bit set");
            read_reg(get_status, val);
            check_equal(val[15], 1'b1, "overflow bit held");
            strobe_once(bus_cmd(clr_rx_ovfl, '0, 1'b0, 1'b0, 1'b1));
            read_reg(get_status, val);
            check_equal(val[15], 1'b0, "overflow bit cleared");
        end

        // service requests, some reads with no request before them
        for (int i = 0; i < n_srq; i++)
        begin
            had = (rand_bits(1) != 0);
            if (had)
            begin
                host_srq = 1'b1;
                wait_cycles(1 + rand_bits(2));
                host_srq = 1'b0;
            end
            wait_cycles(1 + rand_bits(2));
            strobe_once(bus_cmd(get_srq, '0, 1'b1, 1'b0, 1'b0));
            check_equal(srq_bit, had, "srq_bit after read");
        end

        // random counter events, each followed by a byte read
        for (int i = 0; i < n_ctr_evt; i++)
        begin
            // spare status input moves too
            if_mag = (rand_bits(1) != 0);
            pick   = rand_bits(2);
            case (pick)
                0:       strobe_once(bus_cmd(cpu_ctr_ena, '0, 1'b0, 1'b0, 1'b1));
                1:       strobe_once(bus_cmd(cpu_ctr_dis, '0, 1'b0, 1'b0, 1'b1));
                2:       strobe_once(bus_cmd(cpu_ctr_clr, '0, 1'b0, 1'b0, 1'b1));
                default: strobe_once(bus_cmd(get_status, '0, 1'b1, 1'b0, 1'b0));
            endcase
            strobe_once(bus_cmd(get_cpu_ctr0 + rand_bits(2), '0, 1'b1, 1'b0, 1'b0));
            wait_cycles(rand_bits(3));
        end

        // long run then a pause, so gated and free differ in the low bytes
        strobe_once(bus_cmd(cpu_ctr_clr, '0, 1'b0, 1'b0, 1'b1));
        strobe_once(bus_cmd(cpu_ctr_ena, '0, 1'b0, 1'b0, 1'b1));
        wait_cycles(n_long_run);
        strobe_once(bus_cmd(cpu_ctr_dis, '0, 1'b0, 1'b0, 1'b1));
        wait_cycles(n_long_pause);
        for (int k = 0; k < 4; k++)
            strobe_once(bus_cmd(get_cpu_ctr0 + k, '0, 1'b1, 1'b0, 1'b0));

        // host data passes through when nothing is read
        for (int i = 0; i < n_host; i++)
        begin
            step_cycle('0);
            @(negedge cpu_clk);
            check_equal(par, host_dout, "par passthrough");
        end
        wait_cycles(2);

        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* verilog/csr_pkg.sv */
////////////////////
// shared definitions for the CPU control and status block
// opcode bit positions, control bits, identity codes, bus struct
// and the status word, imported by every RTL module
////////////////////

package csr_pkg;

    ////////////////////
    // widths

    localparam int op_w   = 16;
    localparam int tos_w  = 32;
    localparam int ctrl_w = 16;
    localparam int par_w  = 16;
    localparam int ctr_w  = 32;

    ////////////////////
    // opcode bit positions, one bit of op per operation

    // register writes
    localparam int set_ctrl     = 0;
    // events
    localparam int clr_rx_ovfl  = 1;
    // register reads
    localparam int get_status   = 2;
    localparam int get_srq      = 3;
    localparam int get_cpu_ctr0 = 4;
    localparam int get_cpu_ctr1 = 5;
    localparam int get_cpu_ctr2 = 6;
    localparam int get_cpu_ctr3 = 7;
    // counter events
    localparam int cpu_ctr_ena  = 8;
    localparam int cpu_ctr_dis  = 9;
    localparam int cpu_ctr_clr  = 10;

    ////////////////////
    // control word bit positions

    localparam int ctrl_osc_en    = 0;
    localparam int ctrl_eeprom_wp = 1;
    localparam int ctrl_interrupt = 2;

    ////////////////////
    // identity codes reported in the status word

    localparam logic [3:0] fpga_ver = 4'd1;
    localparam logic [3:0] clock_id = 4'd0;
    localparam logic [3:0] fpga_id  = 4'd3;

    // CPU register bus, strobes are single cycle
    typedef struct packed {
        logic [op_w-1:0]  op;
        logic [tos_w-1:0] tos;
        logic             rd_reg;
        logic             wr_reg;
        logic             wr_evt;
    } cpu_bus_t;

    // counter state machine encoding, 2'b11 is unused
    typedef enum logic [1:0] {
        ctr_idle  = 2'b00,
        ctr_run   = 2'b01,
        ctr_pause = 2'b10
    } ctr_state_t;

    // status word fields, msb first
    typedef struct packed {
        logic       rx_overflow;
        ctr_state_t ctr_state;
        logic       if_mag;
        logic [3:0] fpga_ver;
        logic [3:0] clock_id;
        logic [3:0] fpga_id;
    } status_fields_t;

    // built from fields, read by the CPU as a raw word
    typedef union packed {
        logic [par_w-1:0] raw;
        status_fields_t   fields;
    } status_u;

endpackage

/* verilog/csr_regs.sv */
////////////////////
// global control register, sticky converter overflow flag,
// host service request capture and status word assembly
// all state on cpu_clk, strobes come from the CPU register bus
////////////////////

`timescale 1ns/100ps

module csr_regs import csr_pkg::*;
(
    input  logic              cpu_clk,
    input  logic              rx_ovfl_rst,
    input  cpu_bus_t          bus,
    input  logic              adc_ovfl,
    input  logic              host_srq,
    input  logic              if_mag,
    input  ctr_state_t        ctr_state,
    output logic [ctrl_w-1:0] ctrl,
    output logic              adc_clken,
    output logic              eeprom_wp,
    output logic              host_intr,
    output logic              srq_bit,
    output status_u           status
);

    // overflow path
    logic ovfl_meta;
    logic ovfl_sync;
    logic ovfl_prev;
    logic ovfl_edge;
    logic rx_overflow;

    // service request path
    logic srq_noted;
    logic srq_rd;

    ////////////////////
    // control register

    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
            ctrl <= '0;
        // low half of top of stack on a set_ctrl write
        else if (bus.wr_reg && bus.op[set_ctrl])
            ctrl <= bus.tos[ctrl_w-1:0];
    end

    // pins follow the register directly
    assign adc_clken = ctrl[ctrl_osc_en];
    assign eeprom_wp = ctrl[ctrl_eeprom_wp];
    assign host_intr = ctrl[ctrl_interrupt];

    ////////////////////
    // converter overflow

    // two flop synchronizer then a rising edge detector
    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
        begin
            ovfl_meta <= 1'b0;
            ovfl_sync <= 1'b0;
            ovfl_prev <= 1'b0;
        end
        else
        begin
            ovfl_meta <= adc_ovfl;
            ovfl_sync <= ovfl_meta;
            ovfl_prev <= ovfl_sync;
        end
    end

    assign ovfl_edge = ovfl_sync & ~ovfl_prev;

    // sticky flag, the clear event reloads it with this cycle's edge
    // so an overflow that lands on the clear is not lost
    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
            rx_overflow <= 1'b0;
        else if (bus.wr_evt && bus.op[clr_rx_ovfl])
            rx_overflow <= ovfl_edge;
        else
            rx_overflow <= rx_overflow | ovfl_edge;
    end

    ////////////////////
    // host service request

    assign srq_rd = bus.rd_reg && bus.op[get_srq];

    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
        begin
            srq_noted <= 1'b0;
            srq_bit   <= 1'b0;
        end
        else
        begin
            // collect requests between reads
            if (srq_rd)
                srq_noted <= host_srq;
            else
                srq_noted <= srq_noted | host_srq;
            // serial bit shows what was noted up to the read
            if (srq_rd)
                srq_bit <= srq_noted;
        end
    end

    ////////////////////
    // status word

    always_comb
    begin
        status.fields.rx_overflow = rx_overflow;
        status.fields.ctr_state   = ctr_state;
        status.fields.if_mag      = if_mag;
        status.fields.fpga_ver    = fpga_ver;
        status.fields.clock_id    = clock_id;
        status.fields.fpga_id     = fpga_id;
    end

endmodule

/* verilog/ctr_ctl_fsm.sv */
////////////////////
// run, pause and clear control for the CPU cycle counters
// decodes the counter events and drives clear and enable
////////////////////

`timescale 1ns/100ps

module ctr_ctl_fsm import csr_pkg::*;
(
    input  logic       cpu_clk,
    input  logic       rx_ovfl_rst,
    input  cpu_bus_t   bus,
    output ctr_state_t ctr_state,
    output logic       ctr_clr,
    output logic       ctr_ena
);

    logic       evt_clr;
    logic       evt_ena;
    logic       evt_dis;
    ctr_state_t state_nxt;

    // event decode, only on the event strobe
    assign evt_clr = bus.wr_evt && bus.op[cpu_ctr_clr];
    assign evt_ena = bus.wr_evt && bus.op[cpu_ctr_ena];
    assign evt_dis = bus.wr_evt && bus.op[cpu_ctr_dis];

    ////////////////////
    // next state, clear over enable over disable

    always_comb
    begin
        state_nxt = ctr_state;
        if (evt_clr)
            state_nxt = ctr_idle;
        else if (evt_ena)
            state_nxt = ctr_run;
        else
        begin
            case (ctr_state)
                ctr_idle:  state_nxt = ctr_idle;
                ctr_run:   state_nxt = evt_dis ? ctr_pause : ctr_run;
                ctr_pause: state_nxt = ctr_pause;
                // unused encoding falls back to idle
                default:   state_nxt = ctr_idle;
            endcase
        end
    end

    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
            ctr_state <= ctr_idle;
        else
            ctr_state <= state_nxt;
    end

    // clear follows the event strobe, counters zero on the next edge
    assign ctr_clr = evt_clr;
    assign ctr_ena = (ctr_state == ctr_run);

endmodule

/* verilog/ctrl_status_top.sv */
////////////////////
// control and status block beside the embedded CPU
// ties register block, counter FSM, counters and read mux together
////////////////////

`timescale 1ns/100ps

module ctrl_status_top import csr_pkg::*;
(
    input  logic              cpu_clk,
    input  logic              rx_ovfl_rst,
    input  cpu_bus_t          bus,
    input  logic              adc_ovfl,
    input  logic              host_srq,
    input  logic              if_mag,
    input  logic [par_w-1:0]  host_dout,
    output logic [ctrl_w-1:0] ctrl,
    output logic              adc_clken,
    output logic              eeprom_wp,
    output logic              host_intr,
    output logic              srq_bit,
    output logic [par_w-1:0]  par
);

    // internal connections
    status_u          status;
    ctr_state_t       ctr_state;
    logic             ctr_clr;
    logic             ctr_ena;
    logic [ctr_w-1:0] ctr_free;
    logic [ctr_w-1:0] ctr_gated;

    ////////////////////
    // registers and status

    csr_regs u_csr_regs (
        .cpu_clk     (cpu_clk),
        .rx_ovfl_rst (rx_ovfl_rst),
        .bus         (bus),
        .adc_ovfl    (adc_ovfl),
        .host_srq    (host_srq),
        .if_mag      (if_mag),
        .ctr_state   (ctr_state),
        .ctrl        (ctrl),
        .adc_clken   (adc_clken),
        .eeprom_wp   (eeprom_wp),
        .host_intr   (host_intr),
        .srq_bit     (srq_bit),
        .status      (status)
    );

    ////////////////////
    // cycle counters and their control

    ctr_ctl_fsm u_ctr_ctl_fsm (
        .cpu_clk     (cpu_clk),
        .rx_ovfl_rst (rx_ovfl_rst),
        .bus         (bus),
        .ctr_state   (ctr_state),
        .ctr_clr     (ctr_clr),
        .ctr_ena     (ctr_ena)
    );

    cycle_counters u_cycle_counters (
        .cpu_clk     (cpu_clk),
        .rx_ovfl_rst (rx_ovfl_rst),
        .ctr_clr     (ctr_clr),
        .ctr_ena     (ctr_ena),
        .ctr_free    (ctr_free),
        .ctr_gated   (ctr_gated)
    );

    // CPU parallel input
    par_rd_mux u_par_rd_mux (
        .bus         (bus),
        .status      (status),
        .ctr_free    (ctr_free),
        .ctr_gated   (ctr_gated),
        .host_dout   (host_dout),
        .par         (par)
    );

endmodule

/* verilog/cycle_counters.sv */
////////////////////
// pair of 32 bit CPU cycle counters
// free counter counts every cycle, gated counter only while enabled
// so software can compare total against busy cycles
////////////////////

`timescale 1ns/100ps

module cycle_counters import csr_pkg::*;
(
    input  logic             cpu_clk,
    input  logic             rx_ovfl_rst,
    input  logic             ctr_clr,
    input  logic             ctr_ena,
    output logic [ctr_w-1:0] ctr_free,
    output logic [ctr_w-1:0] ctr_gated
);

    ////////////////////
    // free running

    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst || ctr_clr)
            ctr_free <= '0;
        else
            ctr_free <= ctr_free + ctr_w'(1);
    end

    ////////////////////
    // gated by run state

    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst || ctr_clr)
            ctr_gated <= '0;
        // hold while idle or paused
        else if (ctr_ena)
            ctr_gated <= ctr_gated + ctr_w'(1);
    end

endmodule

/* verilog/par_rd_mux.sv */
////////////////////
// CPU parallel input select
// counter byte pairs first, then status, host data otherwise
// purely combinational, valid in the read strobe cycle
////////////////////

`timescale 1ns/100ps

module par_rd_mux import csr_pkg::*;
(
    input  cpu_bus_t         bus,
    input  status_u          status,
    input  logic [ctr_w-1:0] ctr_free,
    input  logic [ctr_w-1:0] ctr_gated,
    input  logic [par_w-1:0] host_dout,
    output logic [par_w-1:0] par
);

    logic rd_ctr0;
    logic rd_ctr1;
    logic rd_ctr2;
    logic rd_ctr3;
    logic rd_status;

    // read selects, qualified by the read strobe
    assign rd_ctr0   = bus.rd_reg && bus.op[get_cpu_ctr0];
    assign rd_ctr1   = bus.rd_reg && bus.op[get_cpu_ctr1];
    assign rd_ctr2   = bus.rd_reg && bus.op[get_cpu_ctr2];
    assign rd_ctr3   = bus.rd_reg && bus.op[get_cpu_ctr3];
    assign rd_status = bus.rd_reg && bus.op[get_status];

    ////////////////////
    // select

    // gated byte high, free byte low, same byte lane from both
    always_comb
    begin
        if (rd_ctr0)
            par = {ctr_gated[7:0], ctr_free[7:0]};
        else if (rd_ctr1)
            par = {ctr_gated[15:8], ctr_free[15:8]};
        else if (rd_ctr2)
            par = {ctr_gated[23:16], ctr_free[23:16]};
        else if (rd_ctr3)
            par = {ctr_gated[31:24], ctr_free[31:24]};
        else if (rd_status)
            par = status.raw;
        else
            // host interface owns the port by default
            par = host_dout;
    end

endmodule
